/* build.f */
logic/datapathPkg.sv
logic/aluBus.sv
logic/registerFile.sv
logic/seqDivider.sv
logic/aluUnit.sv
logic/dataPath.sv
verif/dataPathTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the datapath testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module dataPathTb -f build.f -o simDataPath
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/simDataPath > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
   exit 0
else
   echo "pass message not found in $LOG"
   exit 1
fi

/* verif/dataPathTb.sv */
// testbench for the single-bus datapath, acting as the control unit
`timescale 1ns/1ps

module dataPathTb import datapathPkg::*; ();

   typedef enum {dstRf, dstPc, dstMar, dstHi, dstLo, dstY} regTarget;

   localparam int pairCount  = 20;
   localparam int opRuns     = 9 * pairCount + pairCount + 2;
   localparam int cycleLimit = (opRuns + 40) * 40 + 500; // about 40 cycles per operation

   logic    Clock = 1'b0;
   logic    arstN;
   logic    RFout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout, MDRout;
   logic    RFin, PCin, IRin, RYin, RZin, MARin, RHIin, RLOin, MDRin;
   logic    IncPC, Read, start;
   regIndex RFSelect;
   aluOp    opSelect;
   dataWord Mdatain;
   dataWord busOut;
   logic    finished;

   int seed       = 32'h350d_174a;
   int errorCount = 0;
   int checkCount = 0;
   int cycleCount = 0;

   dataPath dut (.*);

   always #4 Clock = ~Clock;

   // run limit
   always @(posedge Clock) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("timeout: simulation ran past %0d cycles", cycleLimit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic checkValue(string what, logic [63:0] actual, logic [63:0] expected);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic reportTest(string name, int errorsBefore);
      if (errorCount == errorsBefore) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errorCount - errorsBefore);
      end
   endtask

   // expected 64-bit ALU result, upper half zero except for mul and div
   function automatic wideWord refAlu(aluOp op, dataWord a, dataWord b);
      wideWord r;
      case (op)
         opAdd: r = {32'h0, a + b};
         opSub: r = {32'h0, a - b};
         opAnd: r = {32'h0, a & b};
         opOr:  r = {32'h0, a | b};
         opShl: r = {32'h0, a << (b % 32)}; // shift amount wraps at the word width
         opShr: r = {32'h0, a >> (b % 32)};
         opNeg: r = {32'h0, 32'h0 - b};
         opNot: r = {32'h0, ~b};
         opMul: r = 64'(a) * 64'(b);
         opDiv: begin
            if (b == 0) begin
               r = {a, 32'hffff_ffff};
            end else begin
               r = {a % b, a / b}; // remainder high, quotient low
            end
         end
         default: r = '0;
      endcase
      return r;
   endfunction

   task automatic clearControls();
      RFout    <= 1'b0;
      PCout    <= 1'b0;
      IRout    <= 1'b0;
      RYout    <= 1'b0;
      RZLOout  <= 1'b0;
      RZHIout  <= 1'b0;
      MARout   <= 1'b0;
      RHIout   <= 1'b0;
      RLOout   <= 1'b0;
      MDRout   <= 1'b0;
      RFin     <= 1'b0;
      PCin     <= 1'b0;
      IRin     <= 1'b0;
      RYin     <= 1'b0;
      RZin     <= 1'b0;
      MARin    <= 1'b0;
      RHIin    <= 1'b0;
      RLOin    <= 1'b0;
      MDRin    <= 1'b0;
      IncPC    <= 1'b0;
      Read     <= 1'b0;
      start    <= 1'b0;
      RFSelect <= '0;
      opSelect <= opAdd;
      Mdatain  <= '0;
   endtask

   task automatic enableLoad(regTarget t, regIndex idx);
      case (t)
         dstRf: begin
            RFin     <= 1'b1;
            RFSelect <= idx;
         end
         dstPc:  PCin  <= 1'b1;
         dstMar: MARin <= 1'b1;
         dstHi:  RHIin <= 1'b1;
         dstLo:  RLOin <= 1'b1;
         dstY:   RYin  <= 1'b1;
      endcase
   endtask

   task automatic selectSource(regTarget t, regIndex idx);
      case (t)
         dstRf: begin
            RFout    <= 1'b1;
            RFSelect <= idx;
         end
         dstPc:  PCout  <= 1'b1;
         dstMar: MARout <= 1'b1;
         dstHi:  RHIout <= 1'b1;
         dstLo:  RLOout <= 1'b1;
         dstY:   RYout  <= 1'b1;
      endcase
   endtask

   // memory word into MDR, then MDR over the bus into the target
   task automatic loadReg(regTarget t, regIndex idx, dataWord value);
      @(posedge Clock);
      clearControls();
      Mdatain <= value;
      Read    <= 1'b1;
      MDRin   <= 1'b1;
      @(posedge Clock); // MDR takes Mdatain
      clearControls();
      MDRout <= 1'b1;
      enableLoad(t, idx);
      @(posedge Clock); // target takes the bus
      clearControls();
   endtask

   task automatic readReg(regTarget t, regIndex idx, output dataWord value);
      @(posedge Clock);
      clearControls();
      selectSource(t, idx);
      @(negedge Clock);
      value = busOut;
   endtask

   task automatic runAlu(aluOp op, dataWord a, dataWord b, output wideWord result,
                         output int latency);
      dataWord zLow;
      dataWord zHigh;
      loadReg(dstY, '0, a);
      @(posedge Clock);
      clearControls();
      Mdatain <= b;
      Read    <= 1'b1;
      MDRin   <= 1'b1;
      @(posedge Clock);
      clearControls();
      MDRout   <= 1'b1; // b stays on the bus until finished
      opSelect <= op;
      RZin     <= 1'b1;
      start    <= 1'b1;
      @(posedge Clock); // start sampled here
      start <= 1'b0;
      @(negedge Clock);
      checkValue("finished low after start", finished, 1'b0);
      latency = 0;
      do begin
         @(posedge Clock);
         latency++;
         @(negedge Clock);
      end while (!finished && latency < 40);
      if (!finished) begin
         errorCount++;
         $display("ERROR at %0t ns: finished did not rise within 40 cycles of start", $time);
      end
      @(posedge Clock); // Z takes the held result
      clearControls();
      RZLOout <= 1'b1;
      @(negedge Clock);
      zLow = busOut;
      @(posedge Clock);
      clearControls();
      RZHIout <= 1'b1;
      @(negedge Clock);
      zHigh  = busOut;
      result = {zHigh, zLow};
   endtask

   initial begin
      int       errorsBefore;
      int       latency;
      dataWord  value;
      dataWord  opA;
      dataWord  opB;
      dataWord  pcStart;
      wideWord  result;
      dataWord  expected [numRegs];
      aluOp     opList [9];
      regTarget others [4];

      opList = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opNeg, opNot, opMul};
      others = '{dstPc, dstMar, dstHi, dstLo};
      clearControls();
      arstN <= 1'b0;
      repeat (2) @(posedge Clock);
      arstN <= 1'b1;

      // reset state and the hardwired R0
      errorsBefore = errorCount;
      @(negedge Clock);
      checkValue("finished after reset", finished, 1'b1);
      checkValue("idle bus after reset", busOut, '0);
      readReg(dstPc, '0, value);
      checkValue("PC after reset", value, '0);
      readReg(dstHi, '0, value);
      checkValue("HI after reset", value, '0);
      opA = $random(seed);
      loadReg(dstRf, '0, opA);
      readReg(dstRf, '0, value);
      checkValue("R0 after write", value, '0);
      reportTest("reset", errorsBefore);

      // load through MDR, read back on the bus
      errorsBefore = errorCount;
      for (int i = 1; i < numRegs; i++) begin
         expected[i] = $random(seed);
         loadReg(dstRf, regIndex'(i), expected[i]);
      end
      for (int i = 1; i < numRegs; i++) begin
         readReg(dstRf, regIndex'(i), value);
         checkValue($sformatf("R%0d readback", i), value, expected[i]);
      end
      for (int k = 0; k < 4; k++) begin
         opA = $random(seed);
         loadReg(others[k], '0, opA);
         readReg(others[k], '0, value);
         checkValue($sformatf("%s readback", others[k].name()), value, opA);
      end
      reportTest("register load", errorsBefore);

      errorsBefore = errorCount;
      for (int k = 0; k < 9; k++) begin
         for (int j = 0; j < pairCount; j++) begin
            opA = $random(seed);
            opB = $random(seed);
            runAlu(opList[k], opA, opB, result, latency);
            checkValue($sformatf("%s a=%h b=%h", opList[k].name(), opA, opB),
                       result, refAlu(opList[k], opA, opB));
            checkValue("single-cycle latency", latency, 1);
         end
      end
      reportTest("single-cycle ops", errorsBefore);

      errorsBefore = errorCount;
      runAlu(opDiv, 32'd64, 32'd5, result, latency);
      checkValue("64/5 quotient", result[31:0], 32'd12);
      checkValue("64/5 remainder", result[63:32], 32'd4);
      checkValue("divide latency", latency, divIterations + 1);
      for (int j = 0; j < pairCount; j++) begin
         opA = $random(seed);
         opB = $random(seed);
         opB = opB >> j; // spread divisor sizes
         runAlu(opDiv, opA, opB, result, latency);
         checkValue($sformatf("div a=%h b=%h", opA, opB), result, refAlu(opDiv, opA, opB));
         checkValue("divide latency", latency, divIterations + 1);
      end
      reportTest("divide", errorsBefore);

      errorsBefore = errorCount;
      opA = $random(seed);
      runAlu(opDiv, opA, '0, result, latency);
      checkValue("divide by zero quotient", result[31:0], 32'hffff_ffff);
      checkValue("divide by zero remainder", result[63:32], opA);
      reportTest("divide by zero", errorsBefore);

      errorsBefore = errorCount;
      pcStart = $random(seed);
      loadReg(dstPc, '0, pcStart);
      for (int n = 1; n <= 5; n++) begin
         @(posedge Clock);
         clearControls();
         IncPC <= 1'b1;
         readReg(dstPc, '0, value); // its first edge applies the increment
         checkValue($sformatf("PC after %0d increments", n), value, dataWord'(pcStart + n));
      end
      reportTest("PC increment", errorsBefore);

      @(posedge Clock);
      clearControls();
      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* logic/dataPath.sv */
// single-bus datapath top with bus multiplexer, PC, IR, Y, Z, HI, LO, MAR and MDR
`timescale 1ns/1ps

module dataPath import datapathPkg::*; (
   input  logic    Clock,
   input  logic    arstN,
   // out-selects, one-hot onto the bus
   input  logic    RFout,
   input  logic    PCout,
   input  logic    IRout,
   input  logic    RYout,
   input  logic    RZLOout,
   input  logic    RZHIout,
   input  logic    MARout,
   input  logic    RHIout,
   input  logic    RLOout,
   input  logic    MDRout,
   // in-enables
   input  logic    RFin,
   input  logic    PCin,
   input  logic    IRin,
   input  logic    RYin,
   input  logic    RZin,
   input  logic    MARin,
   input  logic    RHIin,
   input  logic    RLOin,
   input  logic    MDRin,
   input  logic    IncPC,
   input  logic    Read,     // MDR takes Mdatain instead of the bus
   input  logic    start,
   input  regIndex RFSelect,
   input  aluOp    opSelect,
   input  dataWord Mdatain,
   output dataWord busOut,
   output logic    finished
);

   dataWord bus;
   dataWord rfData;
   dataWord pc;
   dataWord ir;
   dataWord y;
   wideWord z;
   dataWord hi;
   dataWord lo;
   dataWord mar;
   dataWord mdr;

   logic [9:0] outSelects;

   aluBus alu ();

   registerFile regFile (
      .Clock    (Clock),
      .arstN    (arstN),
      .RFSelect (RFSelect),
      .RFin     (RFin),
      .busIn    (bus),
      .readData (rfData)
   );

   aluUnit aluCore (
      .Clock (Clock),
      .arstN (arstN),
      .alu   (alu.unit)
   );

   // Y is operand a, the bus is operand b
   assign alu.a     = y;
   assign alu.b     = bus;
   assign alu.op    = opSelect;
   assign alu.start = start;
   assign finished  = alu.finished;

   assign outSelects = {MDRout, RLOout, RHIout, MARout, RZHIout,
                        RZLOout, RYout, IRout, PCout, RFout};

   always_comb begin
      case (outSelects)
         10'b00_0000_0001: bus = rfData;
         10'b00_0000_0010: bus = pc;
         10'b00_0000_0100: bus = ir;
         10'b00_0000_1000: bus = y;
         10'b00_0001_0000: bus = z[wordWidth-1:0];
         10'b00_0010_0000: bus = z[2*wordWidth-1:wordWidth];
         10'b00_0100_0000: bus = mar;
         10'b00_1000_0000: bus = hi;
         10'b01_0000_0000: bus = lo;
         10'b10_0000_0000: bus = mdr;
         default:          bus = '0; // idle bus
      endcase
   end

   assign busOut = bus;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         pc  <= '0;
         ir  <= '0;
         y   <= '0;
         z   <= '0;
         hi  <= '0;
         lo  <= '0;
         mar <= '0;
         mdr <= '0;
      end else begin
         if (PCin) begin
            pc <= bus; // a bus load wins over increment
         end else if (IncPC) begin
            pc <= pc + 1'b1;
         end
         if (IRin)  ir  <= bus;
         if (RYin)  y   <= bus;
         if (RZin)  z   <= alu.result;
         if (RHIin) hi  <= bus;
         if (RLOin) lo  <= bus;
         if (MARin) mar <= bus;
         if (MDRin) begin
            mdr <= Read ? Mdatain : bus;
         end
      end
   end

   // two drivers at once would be a control sequencing error
   busOneHot: assert property (
      @(posedge Clock) disable iff (!arstN)
      $onehot0(outSelects)
   ) else $error("more than one bus source selected");

endmodule

/* logic/aluUnit.sv */
// ALU with opcode decode, single-cycle ops, held result and sequential divide
`timescale 1ns/1ps

module aluUnit import datapathPkg::*; (
   input logic Clock,
   input logic arstN,
   aluBus.unit alu
);

   logic    busy;
   logic    divStart;
   logic    divDoneFlag;
   dataWord quotient;
   dataWord remainder;
   wideWord singleResult;
   wideWord product;

   assign divStart = alu.start && (alu.op == opDiv);

   seqDivider divider (
      .Clock     (Clock),
      .arstN     (arstN),
      .start     (divStart),
      .dividend  (alu.a),
      .divisor   (alu.b),
      .quotient  (quotient),
      .remainder (remainder),
      .done      (divDoneFlag)
   );

   assign product = {{wordWidth{1'b0}}, alu.a} * {{wordWidth{1'b0}}, alu.b};

   // one-operand ops work on b, the bus side
   always_comb begin
      case (alu.op)
         opAdd:   singleResult = {{wordWidth{1'b0}}, alu.a + alu.b};
         opSub:   singleResult = {{wordWidth{1'b0}}, alu.a - alu.b};
         opAnd:   singleResult = {{wordWidth{1'b0}}, alu.a & alu.b};
         opOr:    singleResult = {{wordWidth{1'b0}}, alu.a | alu.b};
         opShl:   singleResult = {{wordWidth{1'b0}}, alu.a << alu.b[4:0]};
         opShr:   singleResult = {{wordWidth{1'b0}}, alu.a >> alu.b[4:0]};
         opNeg:   singleResult = {{wordWidth{1'b0}}, -alu.b};
         opNot:   singleResult = {{wordWidth{1'b0}}, ~alu.b};
         opMul:   singleResult = product; // full 64-bit product
         default: singleResult = '0;
      endcase
   end

   // operands and op stay stable from start until finished, so they are read directly
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         busy       <= 1'b0;
         alu.result <= '0;
      end else if (alu.start) begin
         busy <= 1'b1; // finished drops on the sampling edge
      end else if (busy) begin
         if (alu.op == opDiv) begin
            if (divDoneFlag) begin
               alu.result <= {remainder, quotient}; // remainder high, quotient low
               busy       <= 1'b0;
            end
         end else begin
            alu.result <= singleResult;
            busy       <= 1'b0;
         end
      end
   end

   assign alu.finished = !busy;

   // the result capture relies on the host holding a, b and op until finished
   operandsHeld: assert property (
      @(posedge Clock) disable iff (!arstN)
      busy |-> ($stable(alu.a) && $stable(alu.b) && $stable(alu.op))
   ) else $error("ALU operands changed before finished");

endmodule

/* logic/seqDivider.sv */
// unsigned restoring divider, one quotient bit per clock over 32 iterations
`timescale 1ns/1ps

module seqDivider import datapathPkg::*; (
   input  logic    Clock,
   input  logic    arstN,
   input  logic    start,     // loads operands on the sampling edge
   input  dataWord dividend,
   input  dataWord divisor,
   output dataWord quotient,  // also the dividend shift register while busy
   output dataWord remainder, // partial remainder while busy
   output logic    done       // high for one cycle in divDone
);

   divState state;
   divCount iterCount;
   dataWord divisorReg;

   logic [wordWidth:0] shifted; // partial remainder with the next dividend bit
   logic [wordWidth:0] trial;
   logic               notBelow;

   always_comb begin
      shifted  = {remainder, quotient[wordWidth-1]};
      trial    = shifted - {1'b0, divisorReg};
      notBelow = (shifted >= {1'b0, divisorReg});
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         state      <= divIdle;
         iterCount  <= '0;
         quotient   <= '0;
         remainder  <= '0;
         divisorReg <= '0;
      end else begin
         case (state)
            divIdle, divDone: begin
               if (start) begin // load edge
                  quotient   <= dividend;
                  remainder  <= '0;
                  divisorReg <= divisor;
                  iterCount  <= '0;
                  state      <= divBusy;
               end else begin
                  state <= divIdle;
               end
            end
            divBusy: begin
               // restore by keeping the shifted value when the divisor does not fit
               remainder <= notBelow ? trial[wordWidth-1:0] : shifted[wordWidth-1:0];
               quotient  <= {quotient[wordWidth-2:0], notBelow};
               iterCount <= iterCount + 1'b1;
               if (iterCount == divCount'(divIterations - 1)) begin
                  state <= divDone;
               end
            end
            default: state <= divIdle;
         endcase
      end
   end

   // a zero divisor always passes the compare, so quotient ends all ones
   // and the remainder ends equal to the dividend

   assign done = (state == divDone);

   // no back-pressure, the host must wait for finished before a new start
   startWhileBusy: assert property (
      @(posedge Clock) disable iff (!arstN)
      (state == divBusy) |-> !start
   ) else $error("divider started while busy");

endmodule

/* logic/registerFile.sv */
// general register file, sixteen words with R0 wired to zero
`timescale 1ns/1ps

module registerFile import datapathPkg::*; (
   input  logic    Clock,
   input  logic    arstN,
   input  regIndex RFSelect, // one select shared by read and write
   input  logic    RFin,
   input  dataWord busIn,
   output dataWord readData
);

   dataWord regs [numRegs];

   logic writeEn;

   // R0 is never written and keeps its reset zero
   assign writeEn = RFin && (RFSelect != '0);

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[RFSelect] <= busIn;
      end
   end

   // read side is combinational so the bus sees the register in the same cycle
   assign readData = regs[RFSelect];

endmodule

/* logic/aluBus.sv */
// ALU operand, opcode, start/finished handshake and result bundle with host and unit modports
`timescale 1ns/1ps

interface aluBus import datapathPkg::*; ();

   dataWord a;        // operand a, taken from Y
   dataWord b;        // operand b, taken from the bus
   aluOp    op;
   logic    start;    // sampled on the rising edge
   wideWord result;   // held until the next start
   logic    finished; // high while result is valid

   // the datapath side drives operands and start
   modport host (
      output a,
      output b,
      output op,
      output start,
      input  result,
      input  finished
   );

   // the ALU side returns result and finished
   modport unit (
      input  a,
      input  b,
      input  op,
      input  start,
      output result,
      output finished
   );

endinterface

/* logic/datapathPkg.sv */
// shared datapath widths, word types, ALU opcode and divider state encodings
package datapathPkg;

   localparam int wordWidth     = 32;
   localparam int numRegs       = 16;
   localparam int divIterations = 32;

   typedef logic [wordWidth-1:0]             dataWord;  // one bus word
   typedef logic [2*wordWidth-1:0]           wideWord;  // Z register and ALU result
   typedef logic [$clog2(numRegs)-1:0]       regIndex;  // register file select
   typedef logic [$clog2(divIterations)-1:0] divCount;  // divider iteration counter

   // ALU operation codes, as driven on opSelect
   typedef enum logic [4:0] {
      opAdd = 5'b00011,
      opSub = 5'b00100,
      opAnd = 5'b00101,
      opOr  = 5'b00110,
      opShl = 5'b00111,
      opMul = 5'b01000,
      opDiv = 5'b01001,
      opShr = 5'b01010,
      opNeg = 5'b01011,
      opNot = 5'b01100
   } aluOp;

   // restoring divider sequencing
   typedef enum logic [1:0] {
      divIdle,
      divBusy,
      divDone
   } divState;

endpackage
